// File: hw/x86Pkg.sv
package x86Pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int WordW   = 16;    // Data word
    localparam int ByteW   = 8;     // Bus byte
    localparam int AddrW   = 16;
    localparam int RegSelW = 3;     // Register number
    localparam int FlagsW  = 12;

    // Values after reset
    localparam logic [AddrW-1:0]  ResetIp    = 16'h0000;
    localparam logic [FlagsW-1:0] ResetFlags = 12'h002;    // Bit 1 always set

    // ------------------------------
    // Flag bit positions
    // ------------------------------
    localparam int FlagCf = 0;
    localparam int FlagPf = 2;
    localparam int FlagAf = 4;
    localparam int FlagZf = 6;
    localparam int FlagSf = 7;
    localparam int FlagOf = 11;

    // Register numbers
    localparam logic [RegSelW-1:0] RegAx = 3'd0;    // AL / AX
    localparam logic [RegSelW-1:0] RegSp = 3'd4;    // AH / SP

    // ALU op, same order as opcode bits 5:3
    typedef enum logic [2:0] {
        aluAdd, aluOr, aluAdc, aluSbb, aluAnd, aluSub, aluXor, aluCmp
    } aluOpE;

    // Sequencer top states
    typedef enum logic [1:0] {stFetch, stModrm, stExec} seqStateE;

endpackage

// File: hw/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                        clk25,
    input  logic                        arstN,
    input  logic [x86Pkg::RegSelW-1:0]  rdSel,
    input  logic                        rdWide,
    output logic [x86Pkg::WordW-1:0]    rdData,
    input  logic                        wrEn,
    input  logic [x86Pkg::RegSelW-1:0]  wrSel,
    input  logic                        wrWide,
    input  logic [x86Pkg::WordW-1:0]    wrData
);

    // AX CX DX BX SP BP SI DI
    logic [x86Pkg::WordW-1:0] gpr [2**x86Pkg::RegSelW];
    logic [x86Pkg::ByteW-1:0] rdByte;

    // ------------------------------
    // Read side, combinational
    // ------------------------------
    always_comb begin
        // Byte numbers 4..7 are AH..BH
        if (rdSel >= x86Pkg::RegSp)
            rdByte = gpr[rdSel[1:0]][x86Pkg::WordW-1:x86Pkg::ByteW];
        else
            rdByte = gpr[rdSel[1:0]][x86Pkg::ByteW-1:0];
        rdData = rdWide ? gpr[rdSel] : {{(x86Pkg::WordW-x86Pkg::ByteW){1'b0}}, rdByte};
    end

    // ------------------------------
    // Write side
    // ------------------------------
    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) begin
            for (int k = 0; k < 2**x86Pkg::RegSelW; k++) gpr[k] <= '0;
        end else if (wrEn) begin
            if (wrWide)
                gpr[wrSel] <= wrData;
            else if (wrSel >= x86Pkg::RegSp)    // High half, low half kept
                gpr[wrSel[1:0]][x86Pkg::WordW-1:x86Pkg::ByteW] <= wrData[x86Pkg::ByteW-1:0];
            else
                gpr[wrSel[1:0]][x86Pkg::ByteW-1:0] <= wrData[x86Pkg::ByteW-1:0];
        end
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  x86Pkg::aluOpE              op,
    input  logic                       wide,       // 0 = byte, 1 = word
    input  logic [x86Pkg::WordW-1:0]   opA,        // Destination operand
    input  logic [x86Pkg::WordW-1:0]   opB,        // Source operand
    input  logic [x86Pkg::FlagsW-1:0]  flagsIn,
    output logic [x86Pkg::WordW-1:0]   result,
    output logic [x86Pkg::FlagsW-1:0]  flagsOut
);

    logic [x86Pkg::WordW:0] sum;        // Result with carry out on top
    logic [x86Pkg::WordW:0] extA, extB, extC;
    logic       cin, isAdd, isSub;
    logic       msbA, msbB, msbR;
    logic [4:0] nibSum;

    assign isAdd = (op == x86Pkg::aluAdd) || (op == x86Pkg::aluAdc);
    assign isSub = (op == x86Pkg::aluSub) || (op == x86Pkg::aluSbb) || (op == x86Pkg::aluCmp);
    assign cin   = ((op == x86Pkg::aluAdc) || (op == x86Pkg::aluSbb)) ? flagsIn[x86Pkg::FlagCf]
                                                                      : 1'b0;

    assign extA = {1'b0, opA};
    assign extB = {1'b0, opB};
    assign extC = {{x86Pkg::WordW{1'b0}}, cin};

    always_comb begin
        case (op)
            x86Pkg::aluAdd, x86Pkg::aluAdc: sum = extA + extB + extC;
            x86Pkg::aluOr:                  sum = extA | extB;
            x86Pkg::aluAnd:                 sum = extA & extB;
            x86Pkg::aluXor:                 sum = extA ^ extB;
            default:                        sum = extA - extB - extC;   // SBB SUB CMP
        endcase
    end

    assign result = sum[x86Pkg::WordW-1:0];

    // Sign bits at the working width
    assign msbA   = wide ? opA[15] : opA[7];
    assign msbB   = wide ? opB[15] : opB[7];
    assign msbR   = wide ? sum[15] : sum[7];
    assign nibSum = {1'b0, opA[3:0]} + {1'b0, opB[3:0]} + {4'h0, cin};

    // ------------------------------
    // Flags word
    // ------------------------------
    always_comb begin
        flagsOut = x86Pkg::ResetFlags;          // Fixed bit 1
        flagsOut[10:8] = flagsIn[10:8];         // DF IF TF unchanged
        flagsOut[x86Pkg::FlagSf] = msbR;
        flagsOut[x86Pkg::FlagZf] = wide ? (sum[15:0] == 16'h0000) : (sum[7:0] == 8'h00);
        flagsOut[x86Pkg::FlagPf] = ~^sum[7:0];  // Even parity of the low byte
        if (isAdd) begin
            flagsOut[x86Pkg::FlagOf] = ~(msbA ^ msbB) & (msbB ^ msbR);
            flagsOut[x86Pkg::FlagAf] = nibSum[4];
            flagsOut[x86Pkg::FlagCf] = wide ? sum[16] : sum[8];
        end else if (isSub) begin
            flagsOut[x86Pkg::FlagOf] = (msbA ^ msbB) & (msbA ^ msbR);
            flagsOut[x86Pkg::FlagAf] = {1'b0, opA[3:0]} < ({1'b0, opB[3:0]} + {4'h0, cin});
            flagsOut[x86Pkg::FlagCf] = wide ? sum[16] : sum[8];     // Borrow
        end else begin
            flagsOut[x86Pkg::FlagAf] = sum[4];  // Left undefined by the 8086 and taken from bit 4
        end
    end

endmodule

// File: hw/cpuSequencer.sv
`timescale 1ns/1ps

module cpuSequencer (
    input  logic                        clk25,
    input  logic                        arstN,
    input  logic [x86Pkg::ByteW-1:0]    i,
    output logic [x86Pkg::AddrW-1:0]    fetchAddr,
    output logic [x86Pkg::RegSelW-1:0]  rdSel,
    output logic                        rdWide,
    input  logic [x86Pkg::WordW-1:0]    rdData,
    output logic                        wrEn,
    output logic [x86Pkg::RegSelW-1:0]  wrSel,
    output logic                        wrWide,
    output logic [x86Pkg::WordW-1:0]    wrData,
    output x86Pkg::aluOpE               aluOp,
    output logic [x86Pkg::WordW-1:0]    opA,
    output logic [x86Pkg::WordW-1:0]    opB,
    input  logic [x86Pkg::WordW-1:0]    result,
    output logic [x86Pkg::FlagsW-1:0]   flags,
    input  logic [x86Pkg::FlagsW-1:0]   flagsNext,
    output logic                        storeStart,
    output logic [x86Pkg::AddrW-1:0]    storeAddr,
    output logic [x86Pkg::WordW-1:0]    storeData,
    output logic                        storeWide,
    input  logic                        busy
);

    x86Pkg::seqStateE           state;
    logic [1:0]                 step;           // Micro-step inside a state
    logic [x86Pkg::AddrW-1:0]   ip, ea;
    logic [x86Pkg::ByteW-1:0]   opcode, modrm;
    logic                       wide, dir;      // Opcode bits w and d
    logic isAluRm, isAluAcc, isMovImm, isMovSt, isCmp;

    // Instruction class of the latched opcode
    assign isAluRm  = (opcode[7:6] == 2'b00) && !opcode[2];
    assign isAluAcc = (opcode[7:6] == 2'b00) && (opcode[2:1] == 2'b10);
    assign isMovImm = opcode[7:4] == 4'b1011;
    assign isMovSt  = opcode[7:1] == 7'b1000100;   // 88 / 89
    assign isCmp    = aluOp == x86Pkg::aluCmp;

    // ------------------------------
    // Control state
    // ------------------------------
    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) begin
            state  <= x86Pkg::stFetch;
            step   <= 2'd0;
            ip     <= x86Pkg::ResetIp;
            flags  <= x86Pkg::ResetFlags;
            opcode <= '0;
            aluOp  <= x86Pkg::aluAdd;
            wide   <= 1'b0;
            dir    <= 1'b0;
        end else begin
            case (state)
                x86Pkg::stFetch: if (!busy) begin   // Wait out a store
                    opcode <= i;
                    ip     <= ip + 1'b1;
                    step   <= 2'd0;
                    casez (i)
                        8'b00???0??: begin          // ALU rm,reg / reg,rm
                            aluOp <= x86Pkg::aluOpE'(i[5:3]);
                            {dir, wide} <= i[1:0];
                            state <= x86Pkg::stModrm;
                        end
                        8'b00???10?: begin          // ALU acc,imm
                            aluOp <= x86Pkg::aluOpE'(i[5:3]);
                            wide  <= i[0];
                            state <= x86Pkg::stExec;
                        end
                        8'b1011????: begin          // MOV reg,imm
                            wide  <= i[3];
                            state <= x86Pkg::stExec;
                        end
                        8'b1000100?: begin          // MOV [disp16],reg
                            {dir, wide} <= i[1:0];
                            state <= x86Pkg::stModrm;
                        end
                        8'hF5:       flags[x86Pkg::FlagCf] <= ~flags[x86Pkg::FlagCf];  // CMC
                        8'b1111100?: flags[x86Pkg::FlagCf] <= i[0];    // CLC / STC
                        default: ;                  // One-byte no-op
                    endcase
                end
                x86Pkg::stModrm: case (step)
                    2'd0: begin                     // ModRM byte on i
                        ip   <= ip + 1'b1;
                        step <= 2'd1;
                        // Unsupported addressing drops back to fetch
                        if (isMovSt ? (i[7:6] != 2'b00 || i[2:0] != 3'b110) : (i[7:6] != 2'b11))
                            state <= x86Pkg::stFetch;
                    end
                    2'd1: if (isMovSt) begin        // disp16 low
                        ip   <= ip + 1'b1;
                        step <= 2'd2;
                    end else begin                  // rm register read
                        step  <= 2'd0;
                        state <= x86Pkg::stExec;
                    end
                    default: begin                  // disp16 high
                        ip    <= ip + 1'b1;
                        step  <= 2'd0;
                        state <= x86Pkg::stExec;
                    end
                endcase
                default: begin                      // stExec
                    state <= x86Pkg::stFetch;
                    if (isAluRm) begin
                        flags <= flagsNext;
                    end else if (isAluAcc) begin
                        if (step != 2'd2) begin     // Immediate bytes
                            ip    <= ip + 1'b1;
                            step  <= (wide && step == 2'd0) ? 2'd1 : 2'd2;
                            state <= x86Pkg::stExec;
                        end else begin
                            flags <= flagsNext;
                        end
                    end else if (isMovImm) begin
                        ip <= ip + 1'b1;
                        if (wide && step == 2'd0) begin
                            step  <= 2'd1;
                            state <= x86Pkg::stExec;
                        end
                    end
                end
            endcase
        end
    end

    // ------------------------------
    // Operands and address
    // ------------------------------
    always_ff @(posedge clk25) begin
        if (state == x86Pkg::stModrm) begin
            case (step)
                2'd0: begin
                    modrm <= i;
                    if (dir) opA <= rdData;         // reg field value
                    else     opB <= rdData;
                end
                2'd1: begin
                    if (isMovSt) ea[7:0] <= i;
                    else if (dir) opB <= rdData;    // rm field value
                    else          opA <= rdData;
                end
                default: ea[15:8] <= i;
            endcase
        end else if (state == x86Pkg::stExec) begin
            if (isAluAcc && step == 2'd0) begin
                opA <= rdData;                      // AL / AX
                opB <= {8'h00, i};
            end else if (isAluAcc && step == 2'd1) begin
                opB[15:8] <= i;
            end else if (isMovImm && step == 2'd0) begin
                opB <= {8'h00, i};                  // Low byte held for word
            end
        end
    end

    // Register read select
    always_comb begin
        rdSel = modrm[2:0];
        if (state == x86Pkg::stModrm && step == 2'd0) rdSel = i[5:3];
        else if (state == x86Pkg::stExec) rdSel = x86Pkg::RegAx;
    end

    // Write back, one cycle
    always_comb begin
        wrEn   = 1'b0;
        wrSel  = x86Pkg::RegAx;
        wrData = result;
        if (state == x86Pkg::stExec) begin
            if (isAluRm) begin
                wrEn  = !isCmp;                     // CMP keeps destination
                wrSel = dir ? modrm[5:3] : modrm[2:0];
            end else if (isAluAcc) begin
                wrEn = !isCmp && step == 2'd2;
            end else if (isMovImm) begin
                wrEn   = wide == step[0];
                wrSel  = opcode[2:0];
                wrData = wide ? {i, opB[7:0]} : {8'h00, i};
            end
        end
    end

    assign rdWide     = wide;
    assign wrWide     = wide;
    assign fetchAddr  = ip;
    assign storeStart = (state == x86Pkg::stExec) && isMovSt;   // Single-cycle strobe
    assign storeAddr  = ea;
    assign storeData  = opB;
    assign storeWide  = wide;

endmodule

// File: hw/busWriter.sv
`timescale 1ns/1ps

module busWriter (
    input  logic                      clk25,
    input  logic                      arstN,
    input  logic                      storeStart,
    input  logic [x86Pkg::AddrW-1:0]  storeAddr,
    input  logic [x86Pkg::WordW-1:0]  storeData,
    input  logic                      storeWide,
    input  logic [x86Pkg::AddrW-1:0]  fetchAddr,
    output logic                      busy,
    output logic [x86Pkg::AddrW-1:0]  a,
    output logic [x86Pkg::ByteW-1:0]  o,
    output logic                      w
);

    logic [x86Pkg::AddrW-1:0] wrAddr;   // Byte address being written
    logic [x86Pkg::ByteW-1:0] hiByte;
    logic                     hiPending;

    // Strobe and data byte
    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) begin
            w         <= 1'b0;
            o         <= '0;
            hiPending <= 1'b0;
        end else if (storeStart) begin
            w         <= 1'b1;              // Low byte first
            o         <= storeData[x86Pkg::ByteW-1:0];
            hiPending <= storeWide;
        end else if (hiPending) begin
            o         <= hiByte;            // w stays high
            hiPending <= 1'b0;
        end else begin
            w         <= 1'b0;
        end
    end

    always_ff @(posedge clk25) begin
        if (storeStart) begin
            wrAddr <= storeAddr;
            hiByte <= storeData[x86Pkg::WordW-1:x86Pkg::ByteW];
        end else if (hiPending) begin
            wrAddr <= wrAddr + 1'b1;        // Step to high byte
        end
    end

    assign busy = w;
    assign a    = busy ? wrAddr : fetchAddr;

endmodule

// File: hw/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic                      clk25,
    input  logic                      arstN,
    input  logic [x86Pkg::ByteW-1:0]  i,        // Read data
    output logic [x86Pkg::AddrW-1:0]  a,
    output logic [x86Pkg::ByteW-1:0]  o,        // Write data
    output logic                      w         // Write strobe
);

    logic [x86Pkg::AddrW-1:0]   fetchAddr;
    logic [x86Pkg::RegSelW-1:0] rdSel, wrSel;
    logic                       wide, wrEn, wrWide;
    logic [x86Pkg::WordW-1:0]   rdData, wrData;
    x86Pkg::aluOpE              aluOp;
    logic [x86Pkg::WordW-1:0]   opA, opB, result;
    logic [x86Pkg::FlagsW-1:0]  flags, flagsNext;

    // Store request to the bus writer
    logic                       storeStart, storeWide, busy;
    logic [x86Pkg::AddrW-1:0]   storeAddr;
    logic [x86Pkg::WordW-1:0]   storeData;

    cpuSequencer u_seq (
        .clk25, .arstN, .i, .fetchAddr,
        .rdSel, .rdWide(wide), .rdData,
        .wrEn, .wrSel, .wrWide, .wrData,
        .aluOp, .opA, .opB, .result, .flags, .flagsNext,
        .storeStart, .storeAddr, .storeData, .storeWide, .busy
    );

    regFile u_regs (
        .clk25, .arstN, .rdSel, .rdWide(wide), .rdData,
        .wrEn, .wrSel, .wrWide, .wrData
    );

    alu u_alu (
        .op(aluOp), .wide, .opA, .opB, .flagsIn(flags), .result, .flagsOut(flagsNext)
    );

    busWriter u_bus (
        .clk25, .arstN, .storeStart, .storeAddr, .storeData, .storeWide,
        .fetchAddr, .busy, .a, .o, .w
    );

endmodule

// File: testbench/tbClock.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk25,
    output logic arstN
);

    localparam int HalfPeriod  = 20;    // 40 ns period
    localparam int ResetCycles = 5;

    initial begin
        clk25 = 1'b0;
        forever #(HalfPeriod) clk25 = ~clk25;
    end

    // Release away from the rising edge
    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk25);
        @(negedge clk25);
        arstN = 1'b1;
    end

endmodule

// File: testbench/tbChecker.sv
`timescale 1ns/1ps

module writeChecker (
    input  logic                      clk25,
    input  logic                      arstN,
    input  logic [x86Pkg::AddrW-1:0]  a,
    input  logic [x86Pkg::ByteW-1:0]  o,
    input  logic                      w,
    output int                        errCount,
    output int                        seenCount
);

    // Expected writes, in bus order
    logic [x86Pkg::AddrW-1:0] expAddr [$];
    logic [x86Pkg::ByteW-1:0] expData [$];
    int errs = 0;
    int seen = 0;                       // Index of next expected record

    assign errCount  = errs;
    assign seenCount = seen;

    task automatic addExpected(input logic [x86Pkg::AddrW-1:0] addr,
                               input logic [x86Pkg::ByteW-1:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    // ------------------------------
    // Compare each bus write
    // ------------------------------
    always @(posedge clk25) begin
        if (arstN && w) begin
            if (seen < expAddr.size()) begin
                if (a !== expAddr[seen]) begin
                    $display("mismatch at %0d ns: a expected %h, actual %h",
                             $time, expAddr[seen], a);
                    errs++;
                end
                if (o !== expData[seen]) begin
                    $display("mismatch at %0d ns: o expected %h, actual %h",
                             $time, expData[seen], o);
                    errs++;
                end
                seen++;
            end else begin              // Past end of list
                $display("unexpected write at %0d ns to address %h with data %h",
                         $time, a, o);
                errs++;
            end
        end
    end

endmodule

// File: testbench/tbCpu_assert.sv
`timescale 1ns/1ps

module busAssert (
    input logic                      clk25,
    input logic                      arstN,
    input logic [x86Pkg::AddrW-1:0]  a,
    input logic [x86Pkg::ByteW-1:0]  o,
    input logic                      w
);

    int assertErrs = 0;     // Failed assertion count

    // First cycle out of reset
    resetState: assert property (@(posedge clk25) $rose(arstN) |-> !w && a == x86Pkg::ResetIp)
        else begin
            assertErrs++;
            $error("bus not idle at reset address after reset");
        end

    // Word store is the longest burst
    burstLength: assert property (@(posedge clk25) disable iff (!arstN) w && $past(w) |=> !w)
        else begin
            assertErrs++;
            $error("write strobe high for more than two cycles");
        end

    burstAddr: assert property (@(posedge clk25) disable iff (!arstN)
        w && $past(w) |-> a == $past(a) + 16'd1)
        else begin
            assertErrs++;
            $error("second byte of a word store not at the next address");
        end

    noUnknown: assert property (@(posedge clk25) disable iff (!arstN) !$isunknown({o, w}))
        else begin
            assertErrs++;
            $error("o or w unknown after reset");
        end

endmodule

bind cpuTop busAssert u_busAssert (.clk25(clk25), .arstN(arstN), .a(a), .o(o), .w(w));

// File: testbench/tbTop.sv
`timescale 1ns/1ps

module tbTop;

    logic                     clk25, arstN;
    logic [x86Pkg::ByteW-1:0] i, o;
    logic [x86Pkg::AddrW-1:0] a;
    logic                     w;
    logic [x86Pkg::ByteW-1:0] mem [2**x86Pkg::AddrW];     // 64K byte memory
    int errCount, seenCount;
    int expTotal  = 0;
    int progBytes = 0;
    bit loaded    = 1'b0;
    bit loadOk    = 1'b0;

    clockGen u_clk (.clk25, .arstN);

    cpuTop i_cpuTop (.clk25, .arstN, .i, .a, .o, .w);

    writeChecker u_check (.clk25, .arstN, .a, .o, .w, .errCount, .seenCount);

    // ------------------------------
    // Memory model
    // ------------------------------
    always @(negedge clk25) i <= mem[a];            // Read data ahead of the rising edge

    always @(posedge clk25) begin
        if (arstN && w) mem[a] <= o;
    end

    // Fill the memory and read P records as program bytes and W records as expected writes
    task automatic loadVectors();
        int fd, rc, n, j;
        logic [63:0]              tag;
        logic [x86Pkg::AddrW-1:0] addr;
        logic [x86Pkg::ByteW-1:0] data;
        logic [8*128-1:0]         rest;
        for (j = 0; j < 2**x86Pkg::AddrW; j++)      // Fx bytes only so no store runs
            mem[j] = {4'hF, j[15:12] ^ j[11:8] ^ j[7:4] ^ j[3:0]};
        fd = $fopen("testbench/x86_vectors.txt", "r");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "P") begin
                    rc = $fscanf(fd, "%h %d", addr, n);
                    for (j = 0; j < n; j++) begin
                        rc = $fscanf(fd, "%h", data);
                        mem[addr + j] = data;
                        progBytes++;
                    end
                end else if (tag == "W") begin
                    rc = $fscanf(fd, "%h %h", addr, data);
                    u_check.addExpected(addr, data);
                    expTotal++;
                end else begin
                    rc = $fgets(rest, fd);          // Comment to end of line
                end
            end
            $fclose(fd);
            loadOk = 1'b1;
        end
    endtask

    task automatic printSummary(input bit timedOut);
        $display("Checked %0d of %0d writes, %0d errors, %0d assertion failures, %0d missing, %0d timeouts",
                 seenCount, expTotal, errCount, i_cpuTop.u_busAssert.assertErrs,
                 expTotal - seenCount, timedOut);
    endtask

    // ------------------------------
    // Run control
    // ------------------------------
    initial begin
        i = '0;
        loadVectors();
        if (!loadOk) begin
            $display("cannot open testbench/x86_vectors.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            loaded = 1'b1;
            wait (arstN);
            wait (seenCount == expTotal);           // Last expected store done
            repeat (20) @(posedge clk25);           // Catch stray writes
            printSummary(1'b0);
            if (errCount == 0 && i_cpuTop.u_busAssert.assertErrs == 0 && expTotal > 0)
                $display("Simulation completed successfully");
            else
                $display("Simulation failed");
            $finish;
        end
    end

    // Scaled to program length
    initial begin : watchdog
        int limit;
        wait (loaded);
        limit = progBytes * 10 + 200;
        repeat (limit) @(posedge clk25);
        $display("timeout: the program did not finish within %0d clock cycles", limit);
        printSummary(1'b1);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: x86core.f
hw/x86Pkg.sv
hw/regFile.sv
hw/alu.sv
hw/cpuSequencer.sv
hw/busWriter.sv
hw/cpuTop.sv
testbench/tbClock.sv
testbench/tbChecker.sv
testbench/tbCpu_assert.sv
testbench/tbTop.sv

// File: testbench/x86_vectors.txt
# P address count bytes : program bytes, hex, count in decimal
# W address data        : expected bus write, hex, in bus order
P 0000 3 B8 34 12     # MOV AX,1234h
P 0003 4 89 06 00 01  # MOV [0100h],AX
P 0007 2 B4 AB        # MOV AH,ABh
P 0009 2 B0 CD        # MOV AL,CDh
P 000B 2 90 C3        # NOP and RET, both skipped
P 000D 4 89 06 02 01  # MOV [0102h],AX
P 0011 4 88 26 04 01  # MOV [0104h],AH
P 0015 3 BB 0F 0F     # MOV BX,0F0Fh
P 0018 3 B9 3C 3C     # MOV CX,3C3Ch
P 001B 2 01 CB        # ADD BX,CX gives 4B4Bh
P 001D 2 2B CB        # SUB CX,BX gives F0F1h
P 001F 2 20 EB        # AND BL,CH gives BX 4B40h
P 0021 2 0A F1        # OR DH,CL gives DX F100h
P 0023 2 39 CB        # CMP BX,CX leaves BX
P 0025 4 89 1E 06 01  # MOV [0106h],BX
P 0029 4 89 0E 08 01  # MOV [0108h],CX
P 002D 4 89 16 0A 01  # MOV [010Ah],DX
P 0031 2 04 35        # ADD AL,35h gives AX AB02h
P 0033 3 0D 10 10     # OR AX,1010h gives BB12h
P 0036 4 89 06 0C 01  # MOV [010Ch],AX
P 003A 1 F9           # STC
P 003B 2 14 01        # ADC AL,01h gives 14h, CF clear
P 003D 1 F5           # CMC
P 003E 3 1D 04 00     # SBB AX,0004h gives BB0Fh
P 0041 2 F9 F8        # STC then CLC
P 0043 2 14 F0        # ADC AL,F0h gives FFh
P 0045 4 89 06 0E 01  # MOV [010Eh],AX
W 0100 34
W 0101 12
W 0102 CD
W 0103 AB
W 0104 AB             # Byte store, one write
W 0106 40
W 0107 4B
W 0108 F1
W 0109 F0
W 010A 00
W 010B F1
W 010C 12
W 010D BB
W 010E FF
W 010F BB
